/* sources.f */
riscv_v_pkg.sv
riscv_v_bw_lane.sv
riscv_v_shift_unit.sv
riscv_v_logic_ALU.sv
riscv_v_logic_ctrl.sv
riscv_v_logic_top.sv
riscv_v_logic_tb.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = riscv_v_logic_tb
FILELIST   = sources.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || (echo "Simulation ended without result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* riscv_v_logic_tb.sv */
/*
 * Testbench for the vector logical execution slice
 * Random and directed operations over the req/ack front end, checked against a reference model
 */
`timescale 1ns/1ps

module riscv_v_logic_tb;

    localparam int DATA_W  = riscv_v_pkg::VLEN_SLICE;
    localparam int TIMEOUT = 20;

    typedef logic [DATA_W:0] word_t;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic                          req;
    riscv_v_pkg::logic_req_t       req_payload;
    logic                          ack;
    riscv_v_pkg::riscv_v_wb_data_t result;

    riscv_v_pkg::riscv_v_wb_data_t expected;
    integer seed = 76;
    int     error_count = 0;
    int     check_count = 0;
    int     txn_count = 0;
    int     rise_count = 0;
    logic   timed_out = 1'b0;
    logic   ack_prev = 1'b0;

    riscv_v_logic_top #(
        .DATA_W(DATA_W)
    ) riscv_v_logic_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_payload(req_payload),
        .ack        (ack),
        .result     (result)
    );

    always #4 clk = ~clk;

    task automatic check(input word_t got, input word_t exp, input string msg);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    function automatic logic [DATA_W-1:0] rand_word();
        return DATA_W'({$random(seed), $random(seed), $random(seed), $random(seed)});
    endfunction

    // Roughly one bit in sixteen set
    function automatic logic [DATA_W-1:0] sparse_word();
        return rand_word() & rand_word() & rand_word() & rand_word();
    endfunction

    // All ones over the low w bits
    function automatic logic [DATA_W-1:0] elem_mask(input int w);
        return ~({DATA_W{1'b1}} << w);
    endfunction

    // Sign bit of every element set
    function automatic logic [DATA_W-1:0] sign_bits(input int w);
        logic [DATA_W-1:0] m;
        logic [DATA_W-1:0] top;
        m = '0;
        top = elem_mask(w) ^ (elem_mask(w) >> 1);
        for (int j = 0; j < DATA_W / w; j++) begin
            m = m | (top << (j * w));
        end
        return m;
    endfunction

    function automatic riscv_v_pkg::riscv_v_wb_data_t ref_logic(
        input riscv_v_pkg::logic_op_t         op,
        input riscv_v_pkg::osize_vector_t     osize,
        input riscv_v_pkg::riscv_v_alu_data_t a,
        input riscv_v_pkg::riscv_v_alu_data_t b
    );
        int                            w;
        int                            amt;
        logic [DATA_W-1:0]             mask;
        logic [DATA_W-1:0]             ea;
        logic [DATA_W-1:0]             eb;
        logic [DATA_W-1:0]             val;
        logic [DATA_W-1:0]             acc;
        logic [DATA_W-1:0]             res;
        riscv_v_pkg::riscv_v_wb_data_t r;
        case (osize)
            5'b00010: w = 16;
            5'b00100: w = 32;
            5'b01000: w = 64;
            5'b10000: w = 128;
            default:  w = 8;
        endcase
        mask = elem_mask(w);
        res = '0;
        acc = a.data & mask;
        for (int j = 0; j < DATA_W / w; j++) begin
            ea = (a.data >> (j * w)) & mask;
            eb = (b.data >> (j * w)) & mask;
            amt = int'(eb[6:0]) & (w - 1);
            val = '0;
            case (op)
                riscv_v_pkg::OP_AND:    val = ea & eb;
                riscv_v_pkg::OP_OR:     val = ea | eb;
                riscv_v_pkg::OP_XOR:    val = ea ^ eb;
                riscv_v_pkg::OP_SLL:    val = (ea << amt) & mask;
                riscv_v_pkg::OP_SRL:    val = ea >> amt;
                riscv_v_pkg::OP_SRA: begin
                    val = ea >> amt;
                    // Negative element, fill the vacated top bits
                    if ((ea & (mask ^ (mask >> 1))) != '0) begin
                        val = val | (mask & ~(mask >> amt));
                    end
                end
                riscv_v_pkg::OP_REDAND: acc = acc & eb;
                riscv_v_pkg::OP_REDOR:  acc = acc | eb;
                riscv_v_pkg::OP_REDXOR: acc = acc ^ eb;
                default:                val = '0;
            endcase
            res = res | (val << (j * w));
        end
        if (op == riscv_v_pkg::OP_REDAND || op == riscv_v_pkg::OP_REDOR ||
            op == riscv_v_pkg::OP_REDXOR) begin
            res = acc;
        end
        r.valid = a.valid;
        r.data  = res;
        return r;
    endfunction

    // One full four-phase transaction, req held for extra cycles after ack
    task automatic run_op(
        input riscv_v_pkg::logic_op_t     op,
        input riscv_v_pkg::osize_vector_t osize,
        input logic [DATA_W-1:0]          a,
        input logic [DATA_W-1:0]          b,
        input logic                       va,
        input int                         hold
    );
        int edges;
        if (timed_out) begin
            return;
        end
        @(negedge clk);
        req_payload.op         = op;
        req_payload.osize      = osize;
        req_payload.srca.valid = va;
        req_payload.srca.data  = a;
        req_payload.srcb.valid = 1'b1;
        req_payload.srcb.data  = b;
        expected = ref_logic(op, osize, req_payload.srca, req_payload.srcb);
        req = 1'b1;
        txn_count++;
        edges = 0;
        while (!ack && edges < TIMEOUT) begin
            @(negedge clk);
            edges++;
        end
        if (!ack) begin
            $display("Timeout: ack never rose for operation %s", op.name());
            error_count++;
            timed_out = 1'b1;
            return;
        end
        check(word_t'(edges), word_t'(2), "edges from req to ack rise");
        repeat (hold) begin
            @(negedge clk);
            check(word_t'(ack), word_t'(1), "ack while req is held");
        end
        req = 1'b0;
        edges = 0;
        while (ack && edges < TIMEOUT) begin
            @(negedge clk);
            edges++;
        end
        if (ack) begin
            $display("Timeout: ack stayed high after req was released");
            error_count++;
            timed_out = 1'b1;
            return;
        end
        check(word_t'(edges), word_t'(1), "edges from req fall to ack fall");
    endtask

    // Compare result whenever ack is high, first at the rise and then while held
    always @(negedge clk) begin
        if (rst_n && ack) begin
            if (!ack_prev) begin
                rise_count++;
                check(word_t'(result), word_t'(expected), "result at ack rise");
            end else begin
                check(word_t'(result), word_t'(expected), "result while ack held");
            end
        end
        ack_prev = ack;
    end

    initial begin
        riscv_v_pkg::osize_vector_t osize;
        logic [DATA_W-1:0]          a;
        rst_n = 1'b0;
        req = 1'b0;
        req_payload = '0;
        repeat (4) @(negedge clk);
        check(word_t'(ack), word_t'(0), "ack in reset");
        check(word_t'(result), word_t'(0), "result in reset");
        rst_n = 1'b1;
        @(negedge clk);
        check(word_t'(ack), word_t'(0), "ack after reset");
        check(word_t'(result), word_t'(0), "result after reset");

        // Every operation at every width, both valid values, some with late release
        for (int k = 0; k < 9; k++) begin
            for (int s = 0; s < riscv_v_pkg::NUM_SIZES; s++) begin
                osize = riscv_v_pkg::osize_vector_t'(1 << s);
                for (int n = 0; n < 3; n++) begin
                    run_op(riscv_v_pkg::logic_op_t'(k), osize, rand_word(), rand_word(),
                           (n == 1), (n == 2) ? 5 : 0);
                end
            end
        end

        // Shift corners, amount zero and maximum amount on negative elements
        for (int s = 0; s < riscv_v_pkg::NUM_SIZES; s++) begin
            osize = riscv_v_pkg::osize_vector_t'(1 << s);
            a = rand_word() | sign_bits(8 << s);
            run_op(riscv_v_pkg::OP_SLL, osize, a, '0, 1'b1, 0);
            run_op(riscv_v_pkg::OP_SRL, osize, a, '0, 1'b1, 0);
            run_op(riscv_v_pkg::OP_SRA, osize, a, '0, 1'b1, 0);
            run_op(riscv_v_pkg::OP_SLL, osize, a, '1, 1'b0, 0);
            run_op(riscv_v_pkg::OP_SRL, osize, a, '1, 1'b1, 0);
            run_op(riscv_v_pkg::OP_SRA, osize, a, '1, 1'b0, 3);
        end

        // Reductions on sparse and dense operands so every element can flip the result
        for (int s = 0; s < riscv_v_pkg::NUM_SIZES; s++) begin
            osize = riscv_v_pkg::osize_vector_t'(1 << s);
            for (int n = 0; n < 2; n++) begin
                run_op(riscv_v_pkg::OP_REDOR, osize, sparse_word(), sparse_word(),
                       (n == 1), 0);
                run_op(riscv_v_pkg::OP_REDAND, osize, ~sparse_word(), ~sparse_word(),
                       (n == 0), 0);
            end
        end

        @(negedge clk);
        check(word_t'(rise_count), word_t'(txn_count), "ack rises against transactions");
        $display("Checks %0d, errors %0d, transactions %0d, ack rises %0d",
                 check_count, error_count, txn_count, rise_count);
        if (error_count == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : riscv_v_logic_tb

/* riscv_v_logic_top.sv */
/*
 * Vector logical execution slice
 * Front end and combinational ALU
 */
`timescale 1ns/1ps

module riscv_v_logic_top #(
    parameter int DATA_W = riscv_v_pkg::VLEN_SLICE
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  riscv_v_pkg::logic_req_t       req_payload,
    output logic                          ack,
    output riscv_v_pkg::riscv_v_wb_data_t result
);

    riscv_v_pkg::logic_ctrl_t       ctrl;
    riscv_v_pkg::osize_vector_t     osize_vector;
    riscv_v_pkg::riscv_v_alu_data_t srca;
    riscv_v_pkg::riscv_v_alu_data_t srcb;
    riscv_v_pkg::riscv_v_wb_data_t  alu_result;

    riscv_v_logic_ctrl #(
        .DATA_W(DATA_W)
    ) logic_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_payload (req_payload),
        .alu_result  (alu_result),
        .ack         (ack),
        .ctrl        (ctrl),
        .osize_vector(osize_vector),
        .srca        (srca),
        .srcb        (srcb),
        .result      (result)
    );

    riscv_v_logic_ALU #(
        .DATA_W(DATA_W)
    ) logic_alu (
        .ctrl        (ctrl),
        .osize_vector(osize_vector),
        .srca        (srca),
        .srcb        (srcb),
        .result      (alu_result)
    );

endmodule : riscv_v_logic_top

/* riscv_v_logic_ctrl.sv */
/*
 * Front end of the vector logical slice
 * Four-phase req/ack, operation decode, operand capture and result register
 */
`timescale 1ns/1ps

module riscv_v_logic_ctrl #(
    parameter int DATA_W = riscv_v_pkg::VLEN_SLICE
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req,
    input  riscv_v_pkg::logic_req_t        req_payload,
    input  riscv_v_pkg::riscv_v_wb_data_t  alu_result,
    output logic                           ack,
    output riscv_v_pkg::logic_ctrl_t       ctrl,
    output riscv_v_pkg::osize_vector_t     osize_vector,
    output riscv_v_pkg::riscv_v_alu_data_t srca,
    output riscv_v_pkg::riscv_v_alu_data_t srcb,
    output riscv_v_pkg::riscv_v_wb_data_t  result
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUSY = 2'd1,
        HOLD = 2'd2
    } state_t;

    state_t state;

    function automatic riscv_v_pkg::logic_ctrl_t decode_op(input riscv_v_pkg::logic_op_t op);
        riscv_v_pkg::logic_ctrl_t c;
        c = '0;
        case (op)
            riscv_v_pkg::OP_AND:    c.is_and = 1'b1;
            riscv_v_pkg::OP_OR:     c.is_or  = 1'b1;
            riscv_v_pkg::OP_XOR:    c.is_xor = 1'b1;
            riscv_v_pkg::OP_SLL: begin
                c.is_shift = 1'b1;
                c.is_left  = 1'b1;
            end
            riscv_v_pkg::OP_SRL:    c.is_shift = 1'b1;
            riscv_v_pkg::OP_SRA: begin
                c.is_shift = 1'b1;
                c.is_arith = 1'b1;
            end
            riscv_v_pkg::OP_REDAND: begin
                c.is_and    = 1'b1;
                c.is_reduct = 1'b1;
            end
            riscv_v_pkg::OP_REDOR: begin
                c.is_or     = 1'b1;
                c.is_reduct = 1'b1;
            end
            riscv_v_pkg::OP_REDXOR: begin
                c.is_xor    = 1'b1;
                c.is_reduct = 1'b1;
            end
            default:                c = '0;
        endcase
        return c;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            ack          <= 1'b0;
            ctrl         <= '0;
            osize_vector <= '0;
            result       <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req && !ack) begin
                        ctrl         <= decode_op(req_payload.op);
                        osize_vector <= req_payload.osize;
                        state        <= BUSY;
                    end
                end
                BUSY: begin
                    // ALU has settled on the captured operands
                    result <= alu_result;
                    ack    <= 1'b1;
                    state  <= HOLD;
                end
                HOLD: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Operand capture alongside the decode
    always_ff @(posedge clk) begin
        if (state == IDLE && req && !ack) begin
            srca <= req_payload.srca;
            srcb <= req_payload.srcb;
        end
    end

endmodule : riscv_v_logic_ctrl

/* riscv_v_logic_ALU.sv */
/*
 * Vector logical ALU
 * Three bitwise lanes and a shifter, results merged by OR
 */
`timescale 1ns/1ps

module riscv_v_logic_ALU #(
    parameter int DATA_W = riscv_v_pkg::VLEN_SLICE
) (
    input  riscv_v_pkg::logic_ctrl_t       ctrl,
    input  riscv_v_pkg::osize_vector_t     osize_vector,
    input  riscv_v_pkg::riscv_v_alu_data_t srca,
    input  riscv_v_pkg::riscv_v_alu_data_t srcb,
    output riscv_v_pkg::riscv_v_wb_data_t  result
);

    logic [DATA_W-1:0] and_result;
    logic [DATA_W-1:0] or_result;
    logic [DATA_W-1:0] xor_result;
    logic [DATA_W-1:0] shift_result;

    riscv_v_bw_lane #(
        .DATA_W(DATA_W),
        .OP    (riscv_v_pkg::BW_AND)
    ) bw_and (
        .is_reduct   (ctrl.is_reduct),
        .enable      (ctrl.is_and),
        .osize_vector(osize_vector),
        .srca        (srca),
        .srcb        (srcb),
        .result      (and_result)
    );

    riscv_v_bw_lane #(
        .DATA_W(DATA_W),
        .OP    (riscv_v_pkg::BW_OR)
    ) bw_or (
        .is_reduct   (ctrl.is_reduct),
        .enable      (ctrl.is_or),
        .osize_vector(osize_vector),
        .srca        (srca),
        .srcb        (srcb),
        .result      (or_result)
    );

    riscv_v_bw_lane #(
        .DATA_W(DATA_W),
        .OP    (riscv_v_pkg::BW_XOR)
    ) bw_xor (
        .is_reduct   (ctrl.is_reduct),
        .enable      (ctrl.is_xor),
        .osize_vector(osize_vector),
        .srca        (srca),
        .srcb        (srcb),
        .result      (xor_result)
    );

    riscv_v_shift_unit #(
        .DATA_W(DATA_W)
    ) shifter (
        .enable      (ctrl.is_shift),
        .is_left     (ctrl.is_left),
        .is_arith    (ctrl.is_arith),
        .osize_vector(osize_vector),
        .srca        (srca),
        .srcb        (srcb),
        .result      (shift_result)
    );

    // Disabled blocks return zero so a plain OR merges them
    assign result.data  = and_result | or_result | xor_result | shift_result;
    assign result.valid = srca.valid;

endmodule : riscv_v_logic_ALU

/* riscv_v_shift_unit.sv */
/*
 * Vector element shifter
 * Logical left, logical right and arithmetic right at every element width
 */
`timescale 1ns/1ps

module riscv_v_shift_unit #(
    parameter int DATA_W = riscv_v_pkg::VLEN_SLICE
) (
    input  logic                           enable,
    input  logic                           is_left,
    input  logic                           is_arith,
    input  riscv_v_pkg::osize_vector_t     osize_vector,
    input  riscv_v_pkg::riscv_v_alu_data_t srca,
    input  riscv_v_pkg::riscv_v_alu_data_t srcb,
    output logic [DATA_W-1:0]              result
);

    // One full-width shift result per element size
    logic [DATA_W-1:0] shifted [riscv_v_pkg::NUM_SIZES];
    logic [DATA_W-1:0] size_sel;

    for (genvar i = 0; i < riscv_v_pkg::NUM_SIZES; i++) begin : g_size
        localparam int W  = 8 << i;
        localparam int SW = $clog2(W);

        for (genvar j = 0; j < DATA_W / W; j++) begin : g_elem
            logic [W-1:0]  operand;
            logic [SW-1:0] amount;
            logic [W-1:0]  sll_val;
            logic [W-1:0]  srl_val;
            logic [W-1:0]  sra_val;

            assign operand = srca.data[j*W +: W];

            // Amount from the low bits of the matching srcb element
            assign amount = srcb.data[j*W +: SW];

            assign sll_val = operand << amount;
            assign srl_val = operand >> amount;
            // Fills with the element sign bit
            assign sra_val = $signed(operand) >>> amount;

            assign shifted[i][j*W +: W] = is_left  ? sll_val :
                                          is_arith ? sra_val : srl_val;
        end
    end

    // One-hot pick of the active element width
    always_comb begin
        size_sel = '0;
        for (int i = 0; i < riscv_v_pkg::NUM_SIZES; i++) begin
            if (osize_vector[i]) begin
                size_sel |= shifted[i];
            end
        end
    end

    assign result = enable ? size_sel : '0;

endmodule : riscv_v_shift_unit

/* riscv_v_bw_lane.sv */
/*
 * Bitwise lane of the vector logical ALU
 * Applies one operator element-wise or as a reduction over srcb
 */
`timescale 1ns/1ps

module riscv_v_bw_lane #(
    parameter int                 DATA_W = riscv_v_pkg::VLEN_SLICE,
    parameter riscv_v_pkg::bw_op_t OP    = riscv_v_pkg::BW_AND
) (
    input  logic                          is_reduct,
    input  logic                          enable,
    input  riscv_v_pkg::osize_vector_t    osize_vector,
    input  riscv_v_pkg::riscv_v_alu_data_t srca,
    input  riscv_v_pkg::riscv_v_alu_data_t srcb,
    output logic [DATA_W-1:0]             result
);

    logic [DATA_W-1:0] elem_word;
    logic [DATA_W-1:0] red_sel;

    // Fold level i holds srcb reduced to one element of width 8 << i
    logic [DATA_W-1:0] fold [riscv_v_pkg::NUM_SIZES];
    logic [DATA_W-1:0] red_word [riscv_v_pkg::NUM_SIZES];

    function automatic logic [DATA_W-1:0] apply_op(
        input logic [DATA_W-1:0] a,
        input logic [DATA_W-1:0] b
    );
        case (OP)
            riscv_v_pkg::BW_OR:  return a | b;
            riscv_v_pkg::BW_XOR: return a ^ b;
            default:             return a & b;
        endcase
    endfunction

    // Element boundaries do not matter for bitwise operators
    assign elem_word = apply_op(srca.data, srcb.data);

    assign fold[riscv_v_pkg::NUM_SIZES-1] = srcb.data;

    for (genvar i = 0; i < riscv_v_pkg::NUM_SIZES - 1; i++) begin : g_fold
        localparam int W = 8 << i;
        assign fold[i] = apply_op(DATA_W'(fold[i+1][2*W-1:W]), DATA_W'(fold[i+1][W-1:0]));
    end

    // Combine with srca element 0, upper bits come out zero
    for (genvar i = 0; i < riscv_v_pkg::NUM_SIZES; i++) begin : g_red
        localparam int W = 8 << i;
        assign red_word[i] = apply_op(DATA_W'(srca.data[W-1:0]), DATA_W'(fold[i][W-1:0]));
    end

    always_comb begin
        red_sel = '0;
        for (int i = 0; i < riscv_v_pkg::NUM_SIZES; i++) begin
            if (osize_vector[i]) begin
                red_sel |= red_word[i];
            end
        end
    end

    always_comb begin
        if (!enable) begin
            result = '0;
        end else if (is_reduct) begin
            result = red_sel;
        end else begin
            result = elem_word;
        end
    end

endmodule : riscv_v_bw_lane

/* riscv_v_pkg.sv */
/*
 * RISC-V vector logical slice shared definitions
 * Widths, operation and element size encodings, operand and request structs
 */
package riscv_v_pkg;

    // Datapath width of one register group slice
    localparam int VLEN_SLICE = 128;

    // Element widths 8, 16, 32, 64 and 128
    localparam int NUM_SIZES = 5;

    // One-hot element width, bit 0 is 8 bits up to bit 4 at 128 bits
    typedef logic [NUM_SIZES-1:0] osize_vector_t;

    typedef enum logic [3:0] {
        OP_AND    = 4'd0,
        OP_OR     = 4'd1,
        OP_XOR    = 4'd2,
        OP_SLL    = 4'd3,
        OP_SRL    = 4'd4,
        OP_SRA    = 4'd5,
        OP_REDAND = 4'd6,
        OP_REDOR  = 4'd7,
        OP_REDXOR = 4'd8
    } logic_op_t;

    // Operator selection for a bitwise lane
    typedef enum logic [1:0] {
        BW_AND = 2'd0,
        BW_OR  = 2'd1,
        BW_XOR = 2'd2
    } bw_op_t;

    typedef struct packed {
        logic                  valid;
        logic [VLEN_SLICE-1:0] data;
    } riscv_v_alu_data_t;

    typedef struct packed {
        logic                  valid;
        logic [VLEN_SLICE-1:0] data;
    } riscv_v_wb_data_t;

    // Decoded operation flags
    typedef struct packed {
        logic is_reduct;
        logic is_and;
        logic is_or;
        logic is_xor;
        logic is_shift;
        logic is_left;
        logic is_arith;
    } logic_ctrl_t;

    // Request payload held stable while req is high
    typedef struct packed {
        logic_op_t         op;
        osize_vector_t     osize;
        riscv_v_alu_data_t srca;
        riscv_v_alu_data_t srcb;
    } logic_req_t;

endpackage : riscv_v_pkg
